/* render_map_pkg.sv */
package render_map_pkg;

    // bus side
    localparam int unsigned bus_bits = 32;
    localparam int unsigned index_lsb = 2;
    localparam int unsigned platform_index_bits = 4;
    localparam int unsigned monster_index_bits = 1;

    // region field of the bus address selects the object class
    localparam int unsigned region_lsb = 6;
    localparam int unsigned region_bits = 4;
    localparam logic [region_bits-1:0] region_platform = 4'd0;
    localparam logic [region_bits-1:0] region_monster = 4'd2;
    localparam logic [region_bits-1:0] region_role = 4'd5;

    localparam int unsigned platform_slots = 16;
    localparam int unsigned monster_slots = 2;

    // entry layout: kind 23:22, x 21:11, y 10:0
    localparam int unsigned coord_bits = 11;
    localparam int unsigned entry_bits = 24;
    localparam int unsigned kind_bits = 2;
    localparam int unsigned kind_lsb = 22;
    localparam int unsigned x_lsb = 11;
    localparam int unsigned y_lsb = 0;

    // kind codes
    localparam logic [kind_bits-1:0] kind_none = 2'd0;
    // role kind that faces the other way
    localparam logic [kind_bits-1:0] role_kind_mirror = 2'd2;

    // layer identifiers, lowest priority first
    localparam int unsigned layer_platform = 0;
    localparam int unsigned layer_monster = 1;
    localparam int unsigned layer_role = 2;

endpackage

/* sprite_pkg.sv */
package sprite_pkg;

    localparam int unsigned rom_addr_bits = 7;
    localparam int unsigned sprite_id_bits = 3;
    localparam int unsigned pixel_bits = 12;
    localparam int unsigned word_bits = 13;
    // set when the pixel is drawn, clear for see-through
    localparam int unsigned opaque_bit = 12;

    // sprite indices into the image store
    localparam logic [sprite_id_bits-1:0] sprite_green = 3'd0;
    localparam logic [sprite_id_bits-1:0] sprite_light_blue = 3'd1;
    localparam logic [sprite_id_bits-1:0] sprite_purple = 3'd2;
    localparam logic [sprite_id_bits-1:0] sprite_red = 3'd3;
    localparam logic [sprite_id_bits-1:0] sprite_doodle = 3'd4;
    localparam logic [sprite_id_bits-1:0] sprite_doodle_up = 3'd5;

    // image sizes, small stand-ins for the real art
    localparam logic [rom_addr_bits-1:0] green_platform_w = 7'd8;
    localparam logic [rom_addr_bits-1:0] green_platform_h = 7'd2;
    localparam logic [rom_addr_bits-1:0] light_blue_platform_w = 7'd8;
    localparam logic [rom_addr_bits-1:0] light_blue_platform_h = 7'd2;
    localparam logic [rom_addr_bits-1:0] purple_monster_w = 7'd5;
    localparam logic [rom_addr_bits-1:0] purple_monster_h = 7'd4;
    localparam logic [rom_addr_bits-1:0] red_monster_w = 7'd4;
    localparam logic [rom_addr_bits-1:0] red_monster_h = 7'd4;
    localparam logic [rom_addr_bits-1:0] doodle_w = 7'd6;
    localparam logic [rom_addr_bits-1:0] doodle_h = 7'd5;
    localparam logic [rom_addr_bits-1:0] doodle_up_w = 7'd4;
    localparam logic [rom_addr_bits-1:0] doodle_up_h = 7'd6;

    // images sit back to back in one store
    localparam logic [rom_addr_bits-1:0] green_platform_base = 7'd0;
    localparam logic [rom_addr_bits-1:0] light_blue_platform_base =
        green_platform_base + green_platform_w * green_platform_h;
    localparam logic [rom_addr_bits-1:0] purple_monster_base =
        light_blue_platform_base + light_blue_platform_w * light_blue_platform_h;
    localparam logic [rom_addr_bits-1:0] red_monster_base =
        purple_monster_base + purple_monster_w * purple_monster_h;
    localparam logic [rom_addr_bits-1:0] doodle_base =
        red_monster_base + red_monster_w * red_monster_h;
    localparam logic [rom_addr_bits-1:0] doodle_up_base = doodle_base + doodle_w * doodle_h;
    localparam logic [rom_addr_bits-1:0] rom_depth = doodle_up_base + doodle_up_w * doodle_up_h;

    // playfield colours
    localparam logic [pixel_bits-1:0] background_colour = 12'hffd;
    localparam logic [pixel_bits-1:0] grid_colour = 12'hfec;
    localparam int unsigned grid_mask_bits = 5;

    function automatic logic [rom_addr_bits-1:0] sprite_width(
        input logic [sprite_id_bits-1:0] id
    );
        case (id)
            sprite_green: return green_platform_w;
            sprite_light_blue: return light_blue_platform_w;
            sprite_purple: return purple_monster_w;
            sprite_red: return red_monster_w;
            sprite_doodle: return doodle_w;
            sprite_doodle_up: return doodle_up_w;
            default: return '0;
        endcase
    endfunction

    function automatic logic [rom_addr_bits-1:0] sprite_height(
        input logic [sprite_id_bits-1:0] id
    );
        case (id)
            sprite_green: return green_platform_h;
            sprite_light_blue: return light_blue_platform_h;
            sprite_purple: return purple_monster_h;
            sprite_red: return red_monster_h;
            sprite_doodle: return doodle_h;
            sprite_doodle_up: return doodle_up_h;
            default: return '0;
        endcase
    endfunction

    function automatic logic [rom_addr_bits-1:0] sprite_base(
        input logic [sprite_id_bits-1:0] id
    );
        case (id)
            sprite_green: return green_platform_base;
            sprite_light_blue: return light_blue_platform_base;
            sprite_purple: return purple_monster_base;
            sprite_red: return red_monster_base;
            sprite_doodle: return doodle_base;
            sprite_doodle_up: return doodle_up_base;
            default: return '0;
        endcase
    endfunction

endpackage

/* object_table.sv */
`timescale 1ns/10ps

module object_table
    import render_map_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [bus_bits-1:0]   addr,
    input  logic [bus_bits-1:0]   din,
    input  logic                  we,
    output logic [entry_bits-1:0] platform_entries [platform_slots],
    output logic [entry_bits-1:0] monster_entries [monster_slots],
    output logic [entry_bits-1:0] role_entry
);

    logic [region_bits-1:0]         region;
    logic [platform_index_bits-1:0] platform_index;
    logic [monster_index_bits-1:0]  monster_index;
    logic [entry_bits-1:0]          wr_entry;

    assign region = addr[region_lsb +: region_bits];
    assign platform_index = addr[index_lsb +: platform_index_bits];
    assign monster_index = addr[index_lsb +: monster_index_bits];
    // upper data bits carry nothing
    assign wr_entry = din[entry_bits-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < platform_slots; i++) begin
                platform_entries[i] <= '0;
            end
            for (int i = 0; i < monster_slots; i++) begin
                monster_entries[i] <= '0;
            end
            role_entry <= '0;
        end else if (we) begin
            // writes to unused regions fall through
            case (region)
                region_platform: begin
                    platform_entries[platform_index] <= wr_entry;
                end
                region_monster: begin
                    monster_entries[monster_index] <= wr_entry;
                end
                region_role: begin
                    role_entry <= wr_entry;
                end
                default: begin
                end
            endcase
        end
    end

    // a write strobe must come with a resolved address
    a_we_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n) we |-> !$isunknown(addr)
    ) else $error("object_table: write with unknown address");

endmodule

/* sprite_layer.sv */
`timescale 1ns/10ps

module sprite_layer
    import render_map_pkg::*, sprite_pkg::*;
#(
    parameter int unsigned slots = platform_slots,
    parameter int unsigned layer = layer_platform
) (
    input  logic [entry_bits-1:0]     entries [slots],
    input  logic [coord_bits-1:0]     vga_haddr,
    input  logic [coord_bits-1:0]     vga_vaddr,
    output logic                      hit,
    output logic [sprite_id_bits-1:0] sprite_id,
    output logic [rom_addr_bits-1:0]  offset
);

    logic [rom_addr_bits-1:0] sel_w;
    logic [rom_addr_bits-1:0] sel_row;
    logic [rom_addr_bits-1:0] sel_col;

    // image shown for a kind in this class
    function automatic logic [sprite_id_bits-1:0] kind_sprite(input logic [kind_bits-1:0] kind);
        case (layer)
            layer_platform: return (kind == 2'd2) ? sprite_light_blue : sprite_green;
            layer_monster: return (kind == 2'd2) ? sprite_red : sprite_purple;
            default: return (kind == 2'd3) ? sprite_doodle_up : sprite_doodle;
        endcase
    endfunction

    // only the role has a third kind
    function automatic logic kind_valid(input logic [kind_bits-1:0] kind);
        return kind != kind_none && (layer == layer_role || kind != 2'd3);
    endfunction

    always_comb begin
        logic [kind_bits-1:0]      kind;
        logic [coord_bits-1:0]     x;
        logic [coord_bits-1:0]     y;
        logic [coord_bits:0]       dx;
        logic [coord_bits:0]       dy;
        logic [sprite_id_bits-1:0] id;
        logic [rom_addr_bits-1:0]  w;

        hit = 1'b0;
        sprite_id = '0;
        sel_w = '0;
        sel_row = '0;
        sel_col = '0;
        // later slots overwrite earlier ones, so the top index wins
        for (int i = 0; i < slots; i++) begin
            kind = entries[i][kind_lsb +: kind_bits];
            x = entries[i][x_lsb +: coord_bits];
            y = entries[i][y_lsb +: coord_bits];
            id = kind_sprite(kind);
            w = sprite_width(id);
            dx = {1'b0, vga_haddr} - {1'b0, x};
            dy = {1'b0, vga_vaddr} - {1'b0, y};
            if (kind_valid(kind) && vga_haddr >= x && vga_vaddr >= y &&
                dx < w && dy < sprite_height(id)) begin
                hit = 1'b1;
                sprite_id = id;
                sel_w = w;
                sel_row = dy[rom_addr_bits-1:0];
                // mirrored role counts columns from the right edge
                if (layer == layer_role && kind == role_kind_mirror) begin
                    sel_col = w - 7'd1 - dx[rom_addr_bits-1:0];
                end else begin
                    sel_col = dx[rom_addr_bits-1:0];
                end
            end
        end
        offset = sel_row * sel_w + sel_col;
    end

    // chosen slot must land inside its own image
    always_comb begin
        if (hit) begin
            assert final (offset < sprite_width(sprite_id) * sprite_height(sprite_id))
                else $error("sprite_layer: offset outside sprite %0d", sprite_id);
        end
    end

endmodule

/* sprite_rom.sv */
`timescale 1ns/10ps

module sprite_rom
    import sprite_pkg::*;
(
    input  logic [sprite_id_bits-1:0] platform_id,
    input  logic [rom_addr_bits-1:0]  platform_offset,
    input  logic [sprite_id_bits-1:0] monster_id,
    input  logic [rom_addr_bits-1:0]  monster_offset,
    input  logic [sprite_id_bits-1:0] role_id,
    input  logic [rom_addr_bits-1:0]  role_offset,
    output logic [word_bits-1:0]      platform_word,
    output logic [word_bits-1:0]      monster_word,
    output logic [word_bits-1:0]      role_word
);

    // opaque bit plus colour per pixel, all images in one array
    logic [word_bits-1:0]     mem [rom_depth];
    logic [rom_addr_bits-1:0] platform_addr;
    logic [rom_addr_bits-1:0] monster_addr;
    logic [rom_addr_bits-1:0] role_addr;

    initial begin
        $readmemh("sprites.mem", mem);
    end

    assign platform_addr = sprite_base(platform_id) + platform_offset;
    assign monster_addr = sprite_base(monster_id) + monster_offset;
    assign role_addr = sprite_base(role_id) + role_offset;

    assign platform_word = mem[platform_addr];
    assign monster_word = mem[monster_addr];
    assign role_word = mem[role_addr];

    always_comb begin
        assert final (platform_addr < rom_depth && monster_addr < rom_depth &&
                      role_addr < rom_depth)
            else $error("sprite_rom: read past end of image store");
    end

endmodule

/* pixel_compositor.sv */
`timescale 1ns/10ps

module pixel_compositor
    import render_map_pkg::*, sprite_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [coord_bits-1:0] vga_haddr,
    input  logic [coord_bits-1:0] vga_vaddr,
    input  logic                  platform_hit,
    input  logic [word_bits-1:0]  platform_word,
    input  logic                  monster_hit,
    input  logic [word_bits-1:0]  monster_word,
    input  logic                  role_hit,
    input  logic [word_bits-1:0]  role_word,
    output logic [pixel_bits-1:0] vga_data
);

    logic                  on_grid;
    logic                  platform_show;
    logic                  monster_show;
    logic                  role_show;
    logic [pixel_bits-1:0] colour;

    // grid lines every 32 pixels in both directions
    assign on_grid = vga_haddr[grid_mask_bits-1:0] == '0 ||
                     vga_vaddr[grid_mask_bits-1:0] == '0;

    // a see-through word drops its class out of the contest
    assign platform_show = platform_hit && platform_word[opaque_bit];
    assign monster_show = monster_hit && monster_word[opaque_bit];
    assign role_show = role_hit && role_word[opaque_bit];

    always_comb begin
        if (role_show) begin
            colour = role_word[pixel_bits-1:0];
        end else if (monster_show) begin
            colour = monster_word[pixel_bits-1:0];
        end else if (platform_show) begin
            colour = platform_word[pixel_bits-1:0];
        end else if (on_grid) begin
            colour = grid_colour;
        end else begin
            colour = background_colour;
        end
    end

    // one cycle from pixel address to colour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vga_data <= '0;
        end else begin
            vga_data <= colour;
        end
    end

    // catches unloaded image words reaching the screen
    a_vga_data_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(vga_data)
    ) else $error("pixel_compositor: unknown colour on vga_data");

endmodule

/* doodle_renderer.sv */
`timescale 1ns/10ps

module doodle_renderer
    import render_map_pkg::*, sprite_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [bus_bits-1:0]   addr,
    input  logic [bus_bits-1:0]   din,
    input  logic                  we,
    input  logic [coord_bits-1:0] vga_haddr,
    input  logic [coord_bits-1:0] vga_vaddr,
    output logic [pixel_bits-1:0] vga_data
);

    logic [entry_bits-1:0]     platform_entries [platform_slots];
    logic [entry_bits-1:0]     monster_entries [monster_slots];
    logic [entry_bits-1:0]     role_entry;
    // single-slot array for the role layer
    logic [entry_bits-1:0]     role_entries [1];

    logic                      platform_hit;
    logic                      monster_hit;
    logic                      role_hit;
    logic [sprite_id_bits-1:0] platform_id;
    logic [sprite_id_bits-1:0] monster_id;
    logic [sprite_id_bits-1:0] role_id;
    logic [rom_addr_bits-1:0]  platform_offset;
    logic [rom_addr_bits-1:0]  monster_offset;
    logic [rom_addr_bits-1:0]  role_offset;
    logic [word_bits-1:0]      platform_word;
    logic [word_bits-1:0]      monster_word;
    logic [word_bits-1:0]      role_word;

    assign role_entries[0] = role_entry;

    object_table u_object_table (
        .clk              (clk),
        .rst_n            (rst_n),
        .addr             (addr),
        .din              (din),
        .we               (we),
        .platform_entries (platform_entries),
        .monster_entries  (monster_entries),
        .role_entry       (role_entry)
    );

    sprite_layer #(.slots(platform_slots), .layer(layer_platform)) u_platform_layer (
        .entries   (platform_entries),
        .vga_haddr (vga_haddr),
        .vga_vaddr (vga_vaddr),
        .hit       (platform_hit),
        .sprite_id (platform_id),
        .offset    (platform_offset)
    );

    sprite_layer #(.slots(monster_slots), .layer(layer_monster)) u_monster_layer (
        .entries   (monster_entries),
        .vga_haddr (vga_haddr),
        .vga_vaddr (vga_vaddr),
        .hit       (monster_hit),
        .sprite_id (monster_id),
        .offset    (monster_offset)
    );

    sprite_layer #(.slots(1), .layer(layer_role)) u_role_layer (
        .entries   (role_entries),
        .vga_haddr (vga_haddr),
        .vga_vaddr (vga_vaddr),
        .hit       (role_hit),
        .sprite_id (role_id),
        .offset    (role_offset)
    );

    sprite_rom u_sprite_rom (
        .platform_id     (platform_id),
        .platform_offset (platform_offset),
        .monster_id      (monster_id),
        .monster_offset  (monster_offset),
        .role_id         (role_id),
        .role_offset     (role_offset),
        .platform_word   (platform_word),
        .monster_word    (monster_word),
        .role_word       (role_word)
    );

    pixel_compositor u_pixel_compositor (
        .clk           (clk),
        .rst_n         (rst_n),
        .vga_haddr     (vga_haddr),
        .vga_vaddr     (vga_vaddr),
        .platform_hit  (platform_hit),
        .platform_word (platform_word),
        .monster_hit   (monster_hit),
        .monster_word  (monster_word),
        .role_hit      (role_hit),
        .role_word     (role_word),
        .vga_data      (vga_data)
    );

endmodule

/* doodle_renderer_tb.sv */
`timescale 1ns/10ps

module doodle_renderer_tb
    import render_map_pkg::*, sprite_pkg::*;
();

    localparam string test_file = "renderer_tests.txt";
    localparam int unsigned random_seed = 32'h08889c16;
    // random probes stay below every placed object
    localparam int unsigned random_v_min = 256;

    logic                  clk;
    logic                  rst_n;
    logic [bus_bits-1:0]   addr;
    logic [bus_bits-1:0]   din;
    logic                  we;
    logic [coord_bits-1:0] vga_haddr;
    logic [coord_bits-1:0] vga_vaddr;
    logic [pixel_bits-1:0] vga_data;

    string test_lines [$];
    int    limit_cycles = 0;

    doodle_renderer u_doodle_renderer (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (addr),
        .din       (din),
        .we        (we),
        .vga_haddr (vga_haddr),
        .vga_vaddr (vga_vaddr),
        .vga_data  (vga_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_pixel(input logic [pixel_bits-1:0] expected,
                               input logic [pixel_bits-1:0] actual);
        if (actual !== expected) begin
            $display("ERR t=%0t vga_data expected %03h got %03h", $time, expected, actual);
            stop_with_failure();
        end
    endtask

    // grid lines every 32 pixels, flat background elsewhere
    function automatic logic [pixel_bits-1:0] empty_colour(input logic [coord_bits-1:0] h,
                                                           input logic [coord_bits-1:0] v);
        if (h[grid_mask_bits-1:0] == '0 || v[grid_mask_bits-1:0] == '0) begin
            return grid_colour;
        end
        return background_colour;
    endfunction

    task automatic load_tests();
        int    fd;
        string line;
        fd = $fopen(test_file, "r");
        if (fd == 0) begin
            $display("cannot open test file %s", test_file);
            stop_with_failure();
        end
        while ($fgets(line, fd) != 0) begin
            test_lines.push_back(line);
        end
        $fclose(fd);
    endtask

    task automatic write_bus(input logic [bus_bits-1:0] a, input logic [bus_bits-1:0] d);
        @(posedge clk);
        addr <= a;
        din <= d;
        we <= 1'b1;
        @(posedge clk);
        we <= 1'b0;
    endtask

    task automatic probe_pixel(input logic [coord_bits-1:0] h, input logic [coord_bits-1:0] v,
                               input logic [pixel_bits-1:0] expected);
        @(posedge clk);
        vga_haddr <= h;
        vga_vaddr <= v;
        @(posedge clk);
        @(negedge clk);
        check_pixel(expected, vga_data);
    endtask

    task automatic random_probes(input int count);
        logic [coord_bits-1:0] h;
        logic [coord_bits-1:0] v;
        logic [pixel_bits-1:0] pending;
        logic [pixel_bits-1:0] next_expected;
        pending = '0;
        next_expected = '0;
        // one address per cycle, each checked a cycle later
        for (int i = 0; i <= count; i++) begin
            @(posedge clk);
            if (i < count) begin
                h = coord_bits'($urandom);
                v = coord_bits'(random_v_min + $urandom % ((1 << coord_bits) - random_v_min));
                vga_haddr <= h;
                vga_vaddr <= v;
                next_expected = empty_colour(h, v);
            end
            @(negedge clk);
            if (i > 0) begin
                check_pixel(pending, vga_data);
            end
            pending = next_expected;
        end
    endtask

    task automatic run_line(input string line);
        logic [bus_bits-1:0]   a;
        logic [bus_bits-1:0]   d;
        logic [coord_bits-1:0] h;
        logic [coord_bits-1:0] v;
        logic [pixel_bits-1:0] expected;
        int                    count;
        string                 args;
        if (line.len() < 2 || line.getc(0) == "#") begin
            return;
        end
        args = line.substr(1, line.len() - 1);
        case (line.getc(0))
            "W": begin
                if ($sscanf(args, "%h %h", a, d) == 2) begin
                    write_bus(a, d);
                end else begin
                    $display("malformed write line in test file: %s", line);
                    stop_with_failure();
                end
            end
            "P": begin
                if ($sscanf(args, "%d %d %h", h, v, expected) == 3) begin
                    probe_pixel(h, v, expected);
                end else begin
                    $display("malformed probe line in test file: %s", line);
                    stop_with_failure();
                end
            end
            "R": begin
                if ($sscanf(args, "%d", count) == 1) begin
                    random_probes(count);
                end else begin
                    $display("malformed random line in test file: %s", line);
                    stop_with_failure();
                end
            end
            default: begin
                $display("unknown command in test file: %s", line);
                stop_with_failure();
            end
        endcase
    endtask

    // watchdog scaled to the length of the test file
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", limit_cycles);
        stop_with_failure();
    end

    initial begin
        rst_n = 1'b0;
        addr = '0;
        din = '0;
        we = 1'b0;
        vga_haddr = '0;
        vga_vaddr = '0;
        void'($urandom(random_seed));
        load_tests();
        limit_cycles = test_lines.size() * 4 + 200;
        @(posedge clk);
        // output register stays cleared while reset is low
        @(negedge clk);
        check_pixel('0, vga_data);
        @(posedge clk);
        rst_n <= 1'b1;
        foreach (test_lines[i]) begin
            run_line(test_lines[i]);
        end
        @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* sprites.mem */
// one word per pixel, row by row: bit 12 opaque, bits 11:0 colour
// order: green, light-blue, purple monster, red monster, doodle, doodle-up
10a0 10a1 10a2 10a3 10a4 10a5 10a6 10a7 10b0 10b1 10b2 10b3 10b4 10b5 10b6 10b7
13c0 13c1 13c2 13c3 13c4 13c5 13c6 13c7 13d0 13d1 13d2 0f00 13d4 13d5 13d6 13d7
0f00 1501 1502 1503 0f00 1510 1511 1512 1513 1514
1520 1521 1522 1523 1524 1530 1531 1532 1533 1534
1e00 1e01 1e02 1e03 1e10 1e11 1e12 1e13 1e20 1e21 1e22 1e23 0f00 1e31 1e32 0f00
0f00 1d01 1d02 1d03 1d04 0f00 1d10 1d11 1d12 1d13 1d14 1d15
1d20 1d21 1d22 1d23 1d24 1d25 1d30 1d31 1d32 1d33 1d34 1d35
1d40 1d41 1d42 1d43 1d44 1d45
1700 1701 1702 1703 1710 1711 1712 1713 1720 1721 1722 1723
1730 1731 1732 1733 1740 1741 1742 1743 1750 1751 1752 1753

/* renderer_tests.txt */
# W <bus addr hex> <data hex>: bus write; P <h dec> <v dec> <colour hex>: pixel probe
# R <count>: random probes below all objects, expected from the grid rule
P 0 0 fec
P 32 5 fec
P 7 64 fec
P 100 50 ffd
# region 1 is unmapped
W 00000040 00414028
P 43 41 ffd
# green platform in slot 0 at (40,40), light-blue in slot 1 at (100,40)
W 00000000 00414028
W 00000004 00832028
P 43 41 0b3
P 40 40 0a0
P 47 41 0b7
P 48 40 ffd
P 40 42 ffd
P 100 40 3c0
P 107 41 3d7
P 108 41 ffd
P 100 42 ffd
# light-blue slot 9 over green slot 5
W 00000014 00464064
W 00000024 00865864
P 201 100 0a1
P 204 100 3c1
P 206 101 ffd
# platform slot 12, purple monster slot 1 and role stacked
W 00000030 00496096
W 00000084 00498094
W 00000140 00499094
P 302 150 0a2
P 304 150 520
P 306 150 d20
P 306 148 502
# role kinds 1, 2 and 3 at (400,60)
W 00000140 004c803c
P 401 61 d11
W 00000140 008c803c
P 401 61 d14
P 405 64 d40
P 400 60 ffd
W 00000140 00cc803c
P 401 61 711
P 403 65 753
P 404 62 ffd
W 00000140 00000000
P 401 61 ffd
R 200

/* doodle_renderer.f */
render_map_pkg.sv
sprite_pkg.sv
object_table.sv
sprite_layer.sv
sprite_rom.sv
pixel_compositor.sv
doodle_renderer.sv
doodle_renderer_tb.sv

/* run.sh */
#!/bin/sh
# builds the renderer testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module doodle_renderer_tb \
    -f doodle_renderer.f -o doodle_renderer_sim
./obj_dir/doodle_renderer_sim > sim.log 2>&1 || true
cat sim.log
if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi
grep -qF '*** TEST PASSED ***' sim.log
